/* vlog.f */
rtl/rgbw_pkg.sv
rtl/spi_byte_rx.sv
rtl/rgbw_frame_deser.sv
rtl/mult8x8.sv
rtl/color_scaler.sv
rtl/pwm_gen.sv
rtl/rgbw_controller.sv
tb/tb_rgbw_controller.sv

/* run.sh */
#!/bin/sh
# compile the rgbw controller testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_rgbw_controller

./obj_dir/Vtb_rgbw_controller | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* tb/rgbw_stimulus.txt */
// kind nbytes byte0 .. byteN-1 exp_red exp_green exp_blue exp_white, all hex
// kind 01 one frame, 02 cs drops after three bytes, 03 burst, 00 ends the table
// direct, full intensity, one channel zero
01 07 01 ff 00 80 ff 00 40 7f fe 00 3f
// direct, half intensity
01 07 01 80 00 ff 10 c8 01 7f 08 64 00
// direct, low intensity
01 07 01 33 00 c0 33 ff 0a 26 0a 32 01
// palette entry 7, frame colours ignored
01 07 02 ff 07 11 22 33 44 fe 7f 1f 5f
// palette index 0c selects entry 4
01 07 02 a0 0c 00 00 00 00 9f 78 00 00
// off mode
01 07 00 ff 00 ff ff ff ff 00 00 00 00
// three bytes then cs high, then a full direct frame
02 0a 01 ff 00 01 40 00 ff 80 20 00 3f 20 08 00
// unknown mode byte 5a
01 07 5a ff 00 ff ff ff ff 00 00 00 00
// four frames in one cs window, the last one wins
03 1c 01 ff 00 ff ff ff ff 02 ff 03 00 00 00 00
      00 00 00 00 00 00 00 01 c8 00 64 c8 32 fa 4e 9c 27 c3
// end of table
00

/* tb/tb_rgbw_controller.sv */
/*
 * Testbench for the RGBW LED controller.
 * Reads its tests from tb/rgbw_stimulus.txt, sends each byte burst
 * over SPI, checks the byte echo and meters the four PWM high times
 * against the expected duties listed with each test.
 */
`default_nettype none
`timescale 1ns/1ps

module tb_rgbw_controller
    import rgbw_pkg::*;
();

    localparam int PWM_PRESC  = 1;
    // clk cycles per sck half period
    localparam int HALF_SCK   = 4;
    localparam int PERIOD     = 256 * PWM_PRESC;
    // scaler work, then up to one full period until the wrap
    localparam int SETTLE     = 4 * 10 + 8 + PERIOD + 16;
    localparam int STIM_WORDS = 512;

    logic       clk;
    logic       rst;
    logic       sck;
    logic       cs;
    logic       mosi;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic [3:0] pwm;

    logic [7:0] stim [STIM_WORDS];
    logic [7:0] echo_q [$];
    int         hi_cnt [4];
    int         errors;
    int         checks;
    int         n_tests;
    int         cycles;
    int         cycle_limit = 0;

    rgbw_controller #(
        .PWM_PRESC (PWM_PRESC)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .sck      (sck),
        .cs       (cs),
        .mosi     (mosi),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .pwm      (pwm)
    );

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // echo monitor, outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rx_valid === 1'b1) begin
            echo_q.push_back(rx_byte);
        end
    end

    // run limit, set once the test count is known
    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: run still going after %0d clock cycles", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // mode 0, MSB first, mosi changes while sck is low
    task automatic send_byte(input logic [7:0] value);
        int i;
        for (i = 7; i >= 0; i--) begin
            mosi = value[i];
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b1;
            repeat (HALF_SCK) @(negedge clk);
            sck = 1'b0;
        end
    endtask

    task automatic spi_select();
        cs = 1'b0;
        repeat (HALF_SCK) @(negedge clk);
    endtask

    task automatic spi_deselect();
        repeat (HALF_SCK) @(negedge clk);
        cs = 1'b1;
        repeat (2 * HALF_SCK) @(negedge clk);
    endtask

    // high cycles per channel over one full period
    task automatic measure_high();
        int c;
        for (c = 0; c < 4; c++) begin
            hi_cnt[c] = 0;
        end
        repeat (PERIOD) begin
            @(negedge clk);
            for (c = 0; c < 4; c++) begin
                if (pwm[c] === 1'b1) begin
                    hi_cnt[c] = hi_cnt[c] + 1;
                end
            end
        end
    endtask

    // one record: kind, count, bytes, then four expected duties
    task automatic run_test(input int idx, input int base);
        int    kind;
        int    nbytes;
        int    exp_base;
        int    n_cmp;
        int    err_before;
        int    b;
        string kind_name;
        kind       = int'(stim[base]);
        nbytes     = int'(stim[base + 1]);
        exp_base   = base + 2 + nbytes;
        err_before = errors;
        echo_q.delete();
        case (kind)
            1:       kind_name = "frame";
            2:       kind_name = "abort";
            default: kind_name = "burst";
        endcase
        spi_select();
        for (b = 0; b < nbytes; b++) begin
            // abort case, cs goes high mid frame
            if (kind == 2 && b == 3) begin
                spi_deselect();
                spi_select();
            end
            send_byte(stim[base + 2 + b]);
        end
        spi_deselect();
        // last byte strobe, then scaler and pwm wrap
        while (echo_q.size() < nbytes) begin
            @(negedge clk);
        end
        repeat (SETTLE) @(negedge clk);
        check_value("rx_valid pulse count", echo_q.size(), nbytes);
        n_cmp = (echo_q.size() < nbytes) ? echo_q.size() : nbytes;
        for (b = 0; b < n_cmp; b++) begin
            check_value($sformatf("rx_byte[%0d]", b), echo_q[b], stim[base + 2 + b]);
        end
        measure_high();
        check_value("pwm[0] high count", hi_cnt[0], stim[exp_base]);
        check_value("pwm[1] high count", hi_cnt[1], stim[exp_base + 1]);
        check_value("pwm[2] high count", hi_cnt[2], stim[exp_base + 2]);
        check_value("pwm[3] high count", hi_cnt[3], stim[exp_base + 3]);
        $display("test %0d %s, last mode 0x%0h: %s", idx, kind_name,
                 stim[exp_base - FRAME_BYTES], (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        int ptr;
        int t;
        rst     = 1'b1;
        sck     = 1'b0;
        cs      = 1'b1;
        mosi    = 1'b0;
        errors  = 0;
        checks  = 0;
        n_tests = 0;
        $readmemh("tb/rgbw_stimulus.txt", stim);

        // walk the table once to count tests and catch bad records
        ptr = 0;
        while (ptr < STIM_WORDS - 6 && stim[ptr] !== 8'h00 && !$isunknown(stim[ptr])) begin
            if (stim[ptr] > 8'h03 || int'(stim[ptr + 1]) < FRAME_BYTES ||
                ptr + 6 + int'(stim[ptr + 1]) > STIM_WORDS) begin
                errors = errors + 1;
                $display("stimulus record at word %0d is malformed", ptr);
                break;
            end
            n_tests = n_tests + 1;
            ptr = ptr + 6 + int'(stim[ptr + 1]);
        end
        if (n_tests == 0) begin
            errors = errors + 1;
            $display("no tests found in the stimulus file");
        end
        cycle_limit = n_tests * (FRAME_BYTES * 8 * 2 * HALF_SCK + 4 * PERIOD) + 4000;

        // four rising edges in reset
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        ptr = 0;
        for (t = 0; t < n_tests; t++) begin
            run_test(t, ptr);
            ptr = ptr + 6 + int'(stim[ptr + 1]);
        end

        $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/rgbw_controller.sv */
/*
 * Top level of the RGBW LED controller.
 * SPI receiver, frame deserializer, colour scaler and PWM in a chain.
 * Every received byte is echoed on rx_byte with its rx_valid strobe.
 */
`default_nettype none
`timescale 1ns/1ps

module rgbw_controller
    import rgbw_pkg::*;
#(
    parameter int PWM_PRESC = 1
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        sck,
    input  wire        cs,
    input  wire        mosi,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic [3:0] pwm
);

    spi_byte_t   rx;
    rgbw_frame_t frame;
    logic        frame_valid;
    logic        credit_return;
    rgbw_duty_t  duty;
    logic        duty_valid;

    // byte echo
    assign rx_byte  = rx.data;
    assign rx_valid = rx.valid;

    spi_byte_rx i_spi_rx (
        .clk  (clk),
        .rst  (rst),
        .sck  (sck),
        .cs   (cs),
        .mosi (mosi),
        .rx   (rx)
    );

    rgbw_frame_deser i_deser (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .credit_return (credit_return)
    );

    color_scaler i_scaler (
        .clk           (clk),
        .rst           (rst),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .credit_return (credit_return),
        .duty          (duty),
        .duty_valid    (duty_valid)
    );

    pwm_gen #(
        .PWM_PRESC (PWM_PRESC)
    ) i_pwm (
        .clk        (clk),
        .rst        (rst),
        .duty       (duty),
        .duty_valid (duty_valid),
        .pwm        (pwm)
    );

endmodule

`default_nettype wire

/* rtl/pwm_gen.sv */
/*
 * Four-channel PWM with a 256-tick period.
 * A tick comes every PWM_PRESC clk cycles. New duties wait as
 * pending and take effect only at the period wrap.
 * pwm bit 0 is red, then green, blue, white.
 */
`default_nettype none
`timescale 1ns/1ps

module pwm_gen
    import rgbw_pkg::*;
#(
    parameter int PWM_PRESC = 1
) (
    input  wire        clk,
    input  wire        rst,
    input  rgbw_duty_t duty,
    input  wire        duty_valid,
    output logic [3:0] pwm
);

    // at least one bit even when PWM_PRESC is 1
    localparam int PSW = (PWM_PRESC > 1) ? $clog2(PWM_PRESC) : 1;

    logic [PSW-1:0] presc_cnt;
    logic           tick;
    logic [7:0]     cnt;
    logic           wrap;
    rgbw_duty_t     pending;
    rgbw_duty_t     active;

    assign tick = (presc_cnt == PSW'(PWM_PRESC - 1));
    assign wrap = tick && (cnt == 8'hff);

    always_ff @(posedge clk) begin
        if (rst) begin
            presc_cnt <= '0;
            cnt       <= 8'd0;
            pending   <= '0;
            active    <= '0;
            pwm       <= 4'b0000;
        end else begin
            presc_cnt <= tick ? '0 : presc_cnt + 1'b1;
            if (tick) begin
                cnt <= cnt + 8'd1;
            end
            if (duty_valid) begin
                pending <= duty;
            end
            // apply latest duties only between periods
            if (wrap) begin
                active <= pending;
            end
            // high while below duty, so 0 never goes high
            pwm[0] <= (cnt < active.red);
            pwm[1] <= (cnt < active.green);
            pwm[2] <= (cnt < active.blue);
            pwm[3] <= (cnt < active.white);
        end
    end

endmodule

`default_nettype wire

/* rtl/color_scaler.sv */
/*
 * Colour scaler between the frame deserializer and the PWM block.
 * Buffers up to FRAME_CREDITS frames, scales four channels by
 * intensity on one shared multiplier and strobes the duties out.
 * A credit goes back to the deserializer with each result.
 */
`default_nettype none
`timescale 1ns/1ps

module color_scaler
    import rgbw_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  rgbw_frame_t frame,
    input  wire         frame_valid,
    output logic        credit_return,
    output rgbw_duty_t  duty,
    output logic        duty_valid
);

    localparam int PW = (FRAME_CREDITS > 1) ? $clog2(FRAME_CREDITS) : 1;
    localparam int CW = $clog2(FRAME_CREDITS + 1);

    typedef enum logic [2:0] {IDLE, LOAD, WAIT, STORE, DONE} state_e;

    state_e      state;
    rgbw_frame_t fifo_mem [FRAME_CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] fifo_cnt;
    logic          pop;
    rgbw_frame_t head;
    rgbw_duty_t  src;
    logic [1:0]  ch;
    logic [7:0]  op_a;
    logic        mul_ld;
    logic        mul_ready;
    logic [15:0] mul_prod;

    assign head = fifo_mem[rd_ptr];
    assign pop  = (state == DONE);

    // channel source, palette entry or raw frame colour
    always_comb begin
        if (head.mode == MODE_PALETTE) begin
            src = PALETTE[head.color_idx[2:0]];
        end else begin
            src.red   = head.red;
            src.green = head.green;
            src.blue  = head.blue;
            src.white = head.white;
        end
        case (ch)
            2'd0:    op_a = src.red;
            2'd1:    op_a = src.green;
            2'd2:    op_a = src.blue;
            default: op_a = src.white;
        endcase
    end

    assign mul_ld        = (state == LOAD);
    assign duty_valid    = (state == DONE);
    assign credit_return = (state == DONE);

    mult8x8 i_mult (
        .clk     (clk),
        .rst     (rst),
        .ld      (mul_ld),
        .a       (op_a),
        .b       (head.lint),
        .ready   (mul_ready),
        .product (mul_prod)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (frame_valid) begin
                wr_ptr <= (wr_ptr == PW'(FRAME_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FRAME_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_cnt <= fifo_cnt + CW'(frame_valid) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            fifo_mem[wr_ptr] <= frame;
        end
    end

    // ten cycles per channel, load + 8 wait + store
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ch    <= 2'd0;
            duty  <= '0;
        end else begin
            case (state)
                IDLE: if (fifo_cnt != '0) begin
                    ch <= 2'd0;
                    if (head.mode == MODE_DIRECT || head.mode == MODE_PALETTE) begin
                        state <= LOAD;
                    end else begin
                        // off or unknown mode
                        duty  <= '0;
                        state <= DONE;
                    end
                end
                LOAD:  state <= WAIT;
                WAIT:  if (mul_ready) state <= STORE;
                STORE: begin
                    case (ch)
                        2'd0:    duty.red   <= mul_prod[15:8];
                        2'd1:    duty.green <= mul_prod[15:8];
                        2'd2:    duty.blue  <= mul_prod[15:8];
                        default: duty.white <= mul_prod[15:8];
                    endcase
                    ch    <= ch + 2'd1;
                    state <= (ch == 2'd3) ? DONE : LOAD;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the credit scheme upstream keeps the buffer from overflowing
    a_no_overflow : assert property (@(posedge clk) disable iff (rst)
        frame_valid |-> (fifo_cnt < CW'(FRAME_CREDITS)))
        else $error("frame arrived with scaler buffer full");

endmodule

`default_nettype wire

/* rtl/mult8x8.sv */
/*
 * Sequential 8x8 shift-and-add multiplier.
 * Pulse ld with a and b, ready pulses 8 cycles later and product
 * then holds until the next ld.
 */
`default_nettype none
`timescale 1ns/1ps

module mult8x8 (
    input  wire         clk,
    input  wire         rst,
    input  wire         ld,
    input  wire  [7:0]  a,
    input  wire  [7:0]  b,
    output logic        ready,
    output logic [15:0] product
);

    logic [15:0] mcand;
    logic [7:0]  mplier;
    // steps still to go after the load step
    logic [2:0]  step;
    logic        busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            ready <= 1'b0;
            step  <= 3'd0;
        end else begin
            ready <= 1'b0;
            if (ld) begin
                busy <= 1'b1;
                step <= 3'd7;
            end else if (busy) begin
                step <= step - 3'd1;
                if (step == 3'd1) begin
                    busy  <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    // bit 0 of b is handled in the load cycle itself
    always_ff @(posedge clk) begin
        if (ld) begin
            product <= b[0] ? {8'd0, a} : 16'd0;
            mcand   <= {7'd0, a, 1'b0};
            mplier  <= {1'b0, b[7:1]};
        end else if (busy) begin
            if (mplier[0]) begin
                product <= product + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_no_ld_busy : assert property (@(posedge clk) disable iff (rst)
        ld |-> !busy)
        else $error("multiplier loaded while busy");

endmodule

`default_nettype wire

/* rtl/rgbw_frame_deser.sv */
/*
 * Assembles seven received bytes into one colour frame.
 * A byte flagged first restarts assembly, so short frames are lost.
 * Sends frames to the scaler against credits, with one holding
 * register where a newer frame replaces an unsent one.
 */
`default_nettype none
`timescale 1ns/1ps

module rgbw_frame_deser
    import rgbw_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  spi_byte_t   rx,
    output rgbw_frame_t frame,
    output logic        frame_valid,
    input  wire         credit_return
);

    localparam int CW = $clog2(FRAME_CREDITS + 1);

    logic [2:0]                   byte_cnt;
    logic [(FRAME_BYTES-1)*8-1:0] asm_q;
    logic                         frame_done;
    logic                         avail;
    logic                         send_new;
    logic                         send_hold;
    logic [CW-1:0]                credit_q;
    rgbw_frame_t                  full_frame;
    rgbw_frame_t                  hold_q;
    logic                         hold_valid;

    // last byte of a frame, never a first byte
    assign frame_done = rx.valid && !rx.first && (byte_cnt == 3'(FRAME_BYTES - 1));
    assign full_frame = rgbw_frame_t'({asm_q, rx.data});

    // a credit coming back this cycle can be spent at once
    assign avail     = (credit_q != '0) || credit_return;
    assign send_new  = frame_done && avail;
    assign send_hold = hold_valid && avail && !frame_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt    <= 3'd0;
            credit_q    <= CW'(FRAME_CREDITS);
            hold_valid  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            if (rx.valid) begin
                if (rx.first) begin
                    byte_cnt <= 3'd1;
                end else if (frame_done) begin
                    byte_cnt <= 3'd0;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
            frame_valid <= send_new || send_hold;
            credit_q    <= credit_q + CW'(credit_return) - CW'(send_new || send_hold);
            // no credit, park it; latest wins
            if (frame_done && !avail) begin
                hold_valid <= 1'b1;
            end else if (send_new || send_hold) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx.valid) begin
            asm_q <= {asm_q[(FRAME_BYTES-2)*8-1:0], rx.data};
        end
        if (frame_done && !avail) begin
            hold_q <= full_frame;
        end
        if (send_new) begin
            frame <= full_frame;
        end else if (send_hold) begin
            frame <= hold_q;
        end
    end

    // scaler must never hand back more than it was given
    a_credit_max : assert property (@(posedge clk) disable iff (rst)
        credit_q <= CW'(FRAME_CREDITS))
        else $error("credit count above FRAME_CREDITS");

endmodule

`default_nettype wire

/* rtl/spi_byte_rx.sv */
/*
 * SPI slave receiver, mode 0, MSB first.
 * SCK, CS and MOSI are oversampled on clk through two flops each.
 * Emits a one-cycle byte strobe per eight bits, first marks the
 * opening byte after CS falls.
 */
`default_nettype none
`timescale 1ns/1ps

module spi_byte_rx
    import rgbw_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       sck,
    input  wire       cs,
    input  wire       mosi,
    output spi_byte_t rx
);

    // two-flop synchronizers, bit 1 is the safe side
    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic [6:0] shift_q;
    logic [2:0] bit_cnt;
    logic       first_pend;
    logic [7:0] data_q;
    logic       valid_q;
    logic       first_q;

    // rising sck only counts inside a cs window
    assign sck_rise = sck_sync[1] & ~sck_prev & ~cs_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            sck_sync   <= 2'b00;
            cs_sync    <= 2'b11;
            mosi_sync  <= 2'b00;
            sck_prev   <= 1'b0;
            bit_cnt    <= 3'd0;
            first_pend <= 1'b1;
            valid_q    <= 1'b0;
            first_q    <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs};
            mosi_sync <= {mosi_sync[0], mosi};
            sck_prev  <= sck_sync[1];
            valid_q   <= 1'b0;
            if (cs_sync[1]) begin
                // deselected, drop partial bits and re-arm first
                bit_cnt    <= 3'd0;
                first_pend <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    valid_q    <= 1'b1;
                    first_q    <= first_pend;
                    first_pend <= 1'b0;
                end
            end
        end
    end

    // shift register and byte payload
    always_ff @(posedge clk) begin
        if (sck_rise) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                data_q <= {shift_q, mosi_sync[1]};
            end
        end
    end

    assign rx.data  = data_q;
    assign rx.valid = valid_q;
    assign rx.first = first_q;

    // mode 0 data settles before the sampled sck edge
    a_mosi_setup : assert property (@(posedge clk) disable iff (rst)
        sck_rise |-> $stable(mosi_sync[1]))
        else $error("mosi changed in the cycle sck rose");

endmodule

`default_nettype wire

/* rtl/rgbw_pkg.sv */
/*
 * Shared types and constants for the RGBW LED controller.
 * Holds the mode encoding, the byte, frame and duty structs, the
 * frame length, the credit depth and the built-in colour palette.
 * Modules pull it in with a wildcard import in their header.
 */
`default_nettype none

package rgbw_pkg;

    // first byte of every frame
    typedef enum logic [7:0] {
        MODE_OFF     = 8'd0,
        MODE_DIRECT  = 8'd1,
        MODE_PALETTE = 8'd2
    } rgbw_mode_e;

    // one received spi byte
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        // first byte after cs fell
        logic       first;
    } spi_byte_t;

    // field order follows the byte order on the wire
    typedef struct packed {
        rgbw_mode_e mode;
        logic [7:0] lint;
        logic [7:0] color_idx;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbw_frame_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
        logic [7:0] white;
    } rgbw_duty_t;

    localparam int FRAME_BYTES = 7;
    // scaler buffer depth, also the credits held after reset
    localparam int FRAME_CREDITS = 2;

    // indexed by color_idx[2:0]
    localparam rgbw_duty_t PALETTE [8] = '{
        '{8'hff, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'hff, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'hff, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'hff},
        '{8'hff, 8'hc0, 8'h00, 8'h00},
        '{8'h00, 8'hc0, 8'hff, 8'h00},
        '{8'hff, 8'h00, 8'hc0, 8'h00},
        '{8'hff, 8'h80, 8'h20, 8'h60}
    };

endpackage

`default_nettype wire
